// ==== Makefile ====
TOP = sparc_ctl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f sparc_ctl.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

// ==== bench/sparc_ctl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "sparc_ctl_macros.svh"

module sparc_ctl_tb import sparc_ctl_pkg::*; ();

	localparam int N_INSTR = 400;
	localparam int CYCLE_LIMIT = N_INSTR * 12;

	logic Clk;
	logic Clr;
	logic [`WORD_W-1:0] ir;
	logic bcond;
	logic moc;
	state_t state;
	ctl_word_t ctl;

	integer seed = 72;
	int cycle_count = 0;

	op3_t alu_ops [23] = '{OP3_ADD, OP3_ADDCC, OP3_ADDX, OP3_ADDXCC, OP3_SUB, OP3_SUBCC,
		OP3_SUBX, OP3_SUBXCC, OP3_AND, OP3_ANDCC, OP3_ANDN, OP3_ANDNCC, OP3_OR, OP3_ORCC,
		OP3_ORN, OP3_ORNCC, OP3_XOR, OP3_XORCC, OP3_XNOR, OP3_XNORCC, OP3_SLL, OP3_SRL,
		OP3_SRA};
	mem_op_t ld_ops [7] = '{MEM_LD, MEM_LDUB, MEM_LDUH, MEM_LDD, MEM_LDSB, MEM_LDSH,
		MEM_LDSTUB};
	mem_op_t st_ops [4] = '{MEM_ST, MEM_STB, MEM_STH, MEM_STD};

	sparc_ctl sparc_ctl_inst (
		.Clk   (Clk),
		.Clr   (Clr),
		.ir    (ir),
		.bcond (bcond),
		.moc   (moc),
		.state (state),
		.ctl   (ctl)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("the run timed out after %0d cycles", cycle_count);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	// field order: rf_load_en rf_clear_en ir_ld mar_ld mdr_ld pc_ld npc_ld npc_clr fr_ld
	// r_w mov | mem_type mb mm mnp mop mp msa link_sel alu_op
	function automatic ctl_word_t expected_ctl(input state_t s);
		ctl_word_t w;
		case (s)
			S_RESET:       w = 29'b01000101000_00_00_0_00_0_00_0_0_000000;
			S_FETCH_ADDR:  w = 29'b00010000000_00_10_0_11_1_00_0_0_100001;
			S_FETCH_PC:    w = 29'b00000110011_10_00_0_00_0_11_0_0_000000;
			S_FETCH_WAIT:  w = 29'b00100000011_10_00_0_00_0_00_0_0_000000;
			S_ALU:         w = 29'b10000000000_00_00_0_00_0_00_0_0_000000;
			S_ALU_IMM:     w = 29'b10000000000_00_01_0_00_0_00_0_0_000000;
			S_ALU_CC:      w = 29'b10000000100_00_00_0_00_0_00_0_0_000000;
			S_ALU_CC_IMM:  w = 29'b10000000100_00_01_0_00_0_00_0_0_000000;
			S_SETHI:       w = 29'b10000000000_00_10_0_00_1_00_0_0_000000;
			S_LD_ADDR:     w = 29'b00010000010_00_00_0_00_1_00_0_0_000000;
			S_LD_ADDR_IMM: w = 29'b00010000010_00_01_0_00_1_00_0_0_000000;
			S_LD_REQ:      w = 29'b00000000011_00_00_0_00_0_00_0_0_000000;
			S_LD_WAIT:     w = 29'b00001000011_00_00_0_00_0_00_0_0_000000;
			S_LD_WB:       w = 29'b10000000000_00_11_0_00_1_00_0_0_100001;
			S_ST_ADDR:     w = 29'b00010000010_00_00_1_00_1_00_0_0_000000;
			S_ST_ADDR_IMM: w = 29'b00010000010_00_01_1_00_1_00_0_0_000000;
			S_ST_DATA:     w = 29'b00001000000_00_00_1_00_1_00_1_0_100000;
			S_ST_WAIT:     w = 29'b00000000001_00_00_0_00_0_00_0_0_000000;
			S_CALL_LINK:   w = 29'b10000000000_00_10_0_00_1_00_0_1_100001;
			S_JMPL_LINK:   w = 29'b10000000000_00_10_0_00_1_00_0_0_100001;
			S_CALL_JUMP:   w = 29'b00000110000_00_00_0_10_0_11_0_0_000000;
			S_BR_TAKEN:    w = 29'b00000110000_00_00_0_10_0_11_0_0_000000;
			S_JMPL_REG:    w = 29'b00000110000_00_00_0_00_0_11_0_0_000000;
			S_JMPL_IMM:    w = 29'b00000110000_00_01_0_00_0_11_0_0_000000;
			S_BR_SKIP:     w = 29'b00000110000_00_00_0_11_0_11_0_0_000000;
			S_BR_ANNUL:    w = 29'b00000110000_00_00_0_01_0_10_0_0_000000;
			default:       w = '0;
		endcase
		return w;
	endfunction

	function automatic state_t next_expected(input state_t s, input instr_class_t cls,
			input logic cc, input logic imm, input logic annul, input logic bc, input logic mc);
		state_t n;
		n = S_FETCH_ADDR;
		case (s)
			S_FETCH_ADDR: n = S_FETCH_PC;
			S_FETCH_PC:   n = S_FETCH_WAIT;
			S_FETCH_WAIT: n = mc ? S_DECODE : S_FETCH_WAIT;
			S_DECODE: begin
				case (cls)
					CLS_ALU:    n = cc ? (imm ? S_ALU_CC_IMM : S_ALU_CC) : (imm ? S_ALU_IMM : S_ALU);
					CLS_SETHI:  n = S_SETHI;
					CLS_LOAD:   n = imm ? S_LD_ADDR_IMM : S_LD_ADDR;
					CLS_STORE:  n = imm ? S_ST_ADDR_IMM : S_ST_ADDR;
					CLS_CALL:   n = S_CALL_LINK;
					CLS_JMPL:   n = S_JMPL_LINK;
					CLS_BRANCH: n = bc ? S_BR_TAKEN : (annul ? S_BR_ANNUL : S_BR_SKIP);
					default:    n = S_FETCH_ADDR;
				endcase
			end
			S_LD_ADDR, S_LD_ADDR_IMM: n = S_LD_REQ;
			S_LD_REQ:                 n = S_LD_WAIT;
			S_LD_WAIT:                n = mc ? S_LD_WB : S_LD_WAIT;
			S_ST_ADDR, S_ST_ADDR_IMM: n = S_ST_DATA;
			S_ST_DATA:                n = S_ST_WAIT;
			S_ST_WAIT:                n = mc ? S_ST_DONE : S_ST_WAIT;
			S_CALL_LINK:              n = S_CALL_JUMP;
			S_JMPL_LINK:              n = imm ? S_JMPL_IMM : S_JMPL_REG;
			default:                  n = S_FETCH_ADDR;
		endcase
		return n;
	endfunction

	task automatic check_state(input state_t expected, input state_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: state expected %s got %s (%0h)", $time,
				expected.name(), actual.name(), actual);
			$display("sim failed");
			$fatal(1, "state mismatch");
		end
	endtask

	task automatic check_ctl(input ctl_word_t expected, input ctl_word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: ctl expected %h got %h", $time, expected, actual);
			$display("sim failed");
			$fatal(1, "control word mismatch");
		end
	endtask

	// weighted mix, other bits random so imm and annul vary
	task automatic gen_instr(output logic [`WORD_W-1:0] word, output instr_class_t cls,
			output logic set_cc);
		int pick;
		int idx;
		logic [2:0] op2;
		word = $random(seed);
		pick = {$random(seed)} % 16;
		idx = {$random(seed)} % 23;
		op2 = 3'({$random(seed)} % 8);
		set_cc = 1'b0;
		cls = CLS_ILLEGAL;
		if (pick < 5) begin
			word[`OP_HI:`OP_LO] = OP_ARITH;
			word[`OP3_HI:`OP3_LO] = alu_ops[idx];
			// odd entries among the first twenty are the cc forms
			set_cc = (idx < 20) && (idx % 2 == 1);
			cls = CLS_ALU;
		end else if (pick == 5) begin
			word[`OP_HI:`OP_LO] = OP_ARITH;
			word[`OP2_HI:`OP2_LO] = OP2_SETHI;
			// 101 and up would be a shift
			word[`OP3_LO+2:`OP3_LO] = 3'(idx % 5);
			cls = CLS_SETHI;
		end else if (pick < 8) begin
			word[`OP_HI:`OP_LO] = OP_MEM;
			word[`OP3_HI:`OP3_LO] = ld_ops[idx % 7];
			cls = CLS_LOAD;
		end else if (pick < 10) begin
			word[`OP_HI:`OP_LO] = OP_MEM;
			word[`OP3_HI:`OP3_LO] = st_ops[idx % 4];
			cls = CLS_STORE;
		end else if (pick == 10) begin
			word[`OP_HI:`OP_LO] = OP_CALL;
			cls = CLS_CALL;
		end else if (pick == 11) begin
			word[`OP_HI:`OP_LO] = OP_ARITH;
			word[`OP3_HI:`OP3_LO] = OP3_JMPL;
			cls = CLS_JMPL;
		end else if (pick < 15) begin
			word[`OP_HI:`OP_LO] = OP_BRANCH;
			word[`OP2_HI:`OP2_LO] = OP2_BRANCH;
			cls = CLS_BRANCH;
		end else begin
			word[`OP_HI:`OP_LO] = 2'(idx % 3 == 0 ? 2'b00 : (idx % 3 == 1 ? 2'b11 : 2'b10));
			if (idx % 3 == 0)
				word[`OP2_HI:`OP2_LO] = (op2 == 3'b010) ? 3'b110 : op2;
			else if (idx % 3 == 1)
				word[`OP3_HI:`OP3_LO] = 6'b001011;
			else
				word[`OP3_HI:`OP3_LO] = 6'b101011;
		end
	endtask

	initial begin
		state_t exp_state;
		instr_class_t cls;
		logic set_cc;
		logic [31:0] r;
		int n_instr;
		int wait_left;
		logic mov_seen;
		logic done;

		Clr = 1'b0;
		ir = '0;
		bcond = 1'b0;
		moc = 1'b0;
		exp_state = S_RESET;
		cls = CLS_ILLEGAL;
		set_cc = 1'b0;
		n_instr = 0;
		wait_left = 0;
		mov_seen = 1'b0;
		done = 1'b0;

		repeat (2) begin
			@(posedge Clk);
			#1;
			check_state(S_RESET, state);
			check_ctl(expected_ctl(S_RESET), ctl);
		end
		Clr = 1'b1;

		while (!done) begin
			@(posedge Clk);
			#1;
			exp_state = next_expected(exp_state, cls, set_cc, ir[`I_BIT], ir[`ANNUL_BIT],
				bcond, moc);
			check_state(exp_state, state);
			check_ctl(expected_ctl(exp_state), ctl);
			if (exp_state == S_FETCH_ADDR) begin
				if (n_instr == N_INSTR) begin
					done = 1'b1;
				end else begin
					gen_instr(ir, cls, set_cc);
					n_instr++;
				end
			end
			r = $random(seed);
			bcond = r[0];
			// memory responder, moc 0 to 3 cycles after mov rises
			if (ctl.mov) begin
				if (!mov_seen)
					wait_left = {$random(seed)} % 4;
				mov_seen = 1'b1;
				moc = (wait_left == 0);
				if (wait_left > 0)
					wait_left--;
			end else begin
				mov_seen = 1'b0;
				moc = 1'b0;
			end
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/control_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_encoder import sparc_ctl_pkg::*; (
	input wire state_t state,
	output ctl_word_t ctl
);

	always_comb begin
		ctl = '0;
		case (state)
			S_RESET: begin
				ctl.rf_clear_en = 1'b1;
				ctl.pc_ld = 1'b1;
				ctl.npc_clr = 1'b1;
			end

			// mar <- pc, npc + 4 on the alu
			S_FETCH_ADDR: begin
				ctl.mar_ld = 1'b1;
				ctl.mb = 2'b10;
				ctl.mnp = 2'b11;
				ctl.mop = 1'b1;
				ctl.alu_op = 6'b100001;
			end
			S_FETCH_PC: begin
				ctl.pc_ld = 1'b1;
				ctl.npc_ld = 1'b1;
				ctl.r_w = 1'b1;
				ctl.mov = 1'b1;
				ctl.mem_type = 2'b10;
				ctl.mp = 2'b11;
			end
			S_FETCH_WAIT: begin
				ctl.ir_ld = 1'b1;
				ctl.r_w = 1'b1;
				ctl.mov = 1'b1;
				ctl.mem_type = 2'b10;
			end

			S_ALU: begin
				ctl.rf_load_en = 1'b1;
			end
			S_ALU_IMM: begin
				ctl.rf_load_en = 1'b1;
				ctl.mb = 2'b01;
			end
			S_ALU_CC: begin
				ctl.rf_load_en = 1'b1;
				ctl.fr_ld = 1'b1;
			end
			S_ALU_CC_IMM: begin
				ctl.rf_load_en = 1'b1;
				ctl.fr_ld = 1'b1;
				ctl.mb = 2'b01;
			end
			S_SETHI: begin
				ctl.rf_load_en = 1'b1;
				ctl.mb = 2'b10;
				ctl.mop = 1'b1;
			end

			S_LD_ADDR, S_LD_ADDR_IMM: begin
				ctl.mar_ld = 1'b1;
				ctl.r_w = 1'b1;
				ctl.mop = 1'b1;
				ctl.mb = (state == S_LD_ADDR_IMM) ? 2'b01 : 2'b00;
			end
			S_LD_REQ: begin
				ctl.r_w = 1'b1;
				ctl.mov = 1'b1;
			end
			S_LD_WAIT: begin
				ctl.mdr_ld = 1'b1;
				ctl.r_w = 1'b1;
				ctl.mov = 1'b1;
			end
			// write mdr back through the alu
			S_LD_WB: begin
				ctl.rf_load_en = 1'b1;
				ctl.mb = 2'b11;
				ctl.mop = 1'b1;
				ctl.alu_op = 6'b100001;
			end

			S_ST_ADDR, S_ST_ADDR_IMM: begin
				ctl.mar_ld = 1'b1;
				ctl.r_w = 1'b1;
				ctl.mm = 1'b1;
				ctl.mop = 1'b1;
				ctl.mb = (state == S_ST_ADDR_IMM) ? 2'b01 : 2'b00;
			end
			S_ST_DATA: begin
				ctl.mdr_ld = 1'b1;
				ctl.mm = 1'b1;
				ctl.mop = 1'b1;
				ctl.msa = 1'b1;
				ctl.alu_op = 6'b100000;
			end
			S_ST_WAIT: begin
				ctl.mov = 1'b1;
			end

			// link register gets pc
			S_CALL_LINK, S_JMPL_LINK: begin
				ctl.rf_load_en = 1'b1;
				ctl.mb = 2'b10;
				ctl.mop = 1'b1;
				ctl.alu_op = 6'b100001;
				ctl.link_sel = (state == S_CALL_LINK);
			end
			S_CALL_JUMP, S_BR_TAKEN: begin
				ctl.pc_ld = 1'b1;
				ctl.npc_ld = 1'b1;
				ctl.mnp = 2'b10;
				ctl.mp = 2'b11;
			end
			S_JMPL_REG, S_JMPL_IMM: begin
				ctl.pc_ld = 1'b1;
				ctl.npc_ld = 1'b1;
				ctl.mp = 2'b11;
				ctl.mb = (state == S_JMPL_IMM) ? 2'b01 : 2'b00;
			end

			S_BR_SKIP: begin
				ctl.pc_ld = 1'b1;
				ctl.npc_ld = 1'b1;
				ctl.mnp = 2'b11;
				ctl.mp = 2'b11;
			end
			// skip the delay slot
			S_BR_ANNUL: begin
				ctl.pc_ld = 1'b1;
				ctl.npc_ld = 1'b1;
				ctl.mnp = 2'b01;
				ctl.mp = 2'b10;
			end

			default: begin
				ctl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "sparc_ctl_macros.svh"

module instr_decoder import sparc_ctl_pkg::*; (
	input wire logic [`WORD_W-1:0] ir,
	output decoded_t dec
);

	logic [1:0] op;
	logic [5:0] op3;
	logic [2:0] op2;

	assign op = ir[`OP_HI:`OP_LO];
	assign op3 = ir[`OP3_HI:`OP3_LO];
	assign op2 = ir[`OP2_HI:`OP2_LO];

	always_comb begin
		dec.cls = CLS_ILLEGAL;
		dec.set_cc = 1'b0;
		dec.imm = ir[`I_BIT];
		dec.annul = ir[`ANNUL_BIT];

		case (op)
			OP_CALL: begin
				dec.cls = CLS_CALL;
			end

			OP_BRANCH: begin
				if (op2 == OP2_BRANCH)
					dec.cls = CLS_BRANCH;
			end

			OP_ARITH: begin
				case (op3)
					OP3_ADD, OP3_ADDCC, OP3_ADDX, OP3_ADDXCC,
					OP3_SUB, OP3_SUBCC, OP3_SUBX, OP3_SUBXCC,
					OP3_AND, OP3_ANDCC, OP3_ANDN, OP3_ANDNCC,
					OP3_OR, OP3_ORCC, OP3_ORN, OP3_ORNCC,
					OP3_XOR, OP3_XORCC, OP3_XNOR, OP3_XNORCC: begin
						dec.cls = CLS_ALU;
						dec.set_cc = op3[4];
					end
					// shifts have no cc form
					OP3_SLL, OP3_SRL, OP3_SRA: begin
						dec.cls = CLS_ALU;
					end
					OP3_JMPL: begin
						dec.cls = CLS_JMPL;
					end
					default: begin
						// sethi shares the 100 prefix with the shifts
						if (op2 == OP2_SETHI)
							dec.cls = CLS_SETHI;
					end
				endcase
			end

			OP_MEM: begin
				case (op3)
					MEM_LD, MEM_LDUB, MEM_LDUH, MEM_LDD,
					MEM_LDSB, MEM_LDSH, MEM_LDSTUB: begin
						dec.cls = CLS_LOAD;
					end
					MEM_ST, MEM_STB, MEM_STH, MEM_STD: begin
						dec.cls = CLS_STORE;
					end
					default: begin
						dec.cls = CLS_ILLEGAL;
					end
				endcase
			end

			default: begin
				dec.cls = CLS_ILLEGAL;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/micro_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module micro_sequencer import sparc_ctl_pkg::*; (
	input wire logic Clk,
	input wire logic Clr,
	input wire decoded_t dec,
	input wire logic bcond,
	input wire logic moc,
	output state_t state
);

	state_t next_state;

	always_ff @(posedge Clk or negedge Clr) begin
		if (!Clr)
			state <= S_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = S_FETCH_ADDR;
		case (state)
			S_RESET:      next_state = S_FETCH_ADDR;
			S_FETCH_ADDR: next_state = S_FETCH_PC;
			S_FETCH_PC:   next_state = S_FETCH_WAIT;
			S_FETCH_WAIT: next_state = moc ? S_DECODE : S_FETCH_WAIT;

			S_DECODE: begin
				case (dec.cls)
					CLS_ALU: begin
						case ({dec.set_cc, dec.imm})
							2'b00:   next_state = S_ALU;
							2'b01:   next_state = S_ALU_IMM;
							2'b10:   next_state = S_ALU_CC;
							default: next_state = S_ALU_CC_IMM;
						endcase
					end
					CLS_SETHI: next_state = S_SETHI;
					CLS_LOAD:  next_state = dec.imm ? S_LD_ADDR_IMM : S_LD_ADDR;
					CLS_STORE: next_state = dec.imm ? S_ST_ADDR_IMM : S_ST_ADDR;
					CLS_CALL:  next_state = S_CALL_LINK;
					CLS_JMPL:  next_state = S_JMPL_LINK;
					CLS_BRANCH: begin
						// annul only matters when not taken
						if (bcond)
							next_state = S_BR_TAKEN;
						else if (!dec.annul)
							next_state = S_BR_SKIP;
						else
							next_state = S_BR_ANNUL;
					end
					default: next_state = S_FETCH_ADDR;
				endcase
			end

			// load path
			S_LD_ADDR, S_LD_ADDR_IMM: next_state = S_LD_REQ;
			S_LD_REQ:                 next_state = S_LD_WAIT;
			S_LD_WAIT:                next_state = moc ? S_LD_WB : S_LD_WAIT;

			// store path
			S_ST_ADDR, S_ST_ADDR_IMM: next_state = S_ST_DATA;
			S_ST_DATA:                next_state = S_ST_WAIT;
			S_ST_WAIT:                next_state = moc ? S_ST_DONE : S_ST_WAIT;

			S_CALL_LINK: next_state = S_CALL_JUMP;
			S_JMPL_LINK: next_state = dec.imm ? S_JMPL_IMM : S_JMPL_REG;

			// last state of every class
			default: next_state = S_FETCH_ADDR;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/sparc_ctl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "sparc_ctl_macros.svh"

module sparc_ctl import sparc_ctl_pkg::*; (
	input wire logic Clk,
	input wire logic Clr,
	input wire logic [`WORD_W-1:0] ir,
	input wire logic bcond,
	input wire logic moc,
	output state_t state,
	output ctl_word_t ctl
);

	decoded_t dec;

	instr_decoder instr_decoder_inst (
		.ir  (ir),
		.dec (dec)
	);

	micro_sequencer micro_sequencer_inst (
		.Clk   (Clk),
		.Clr   (Clr),
		.dec   (dec),
		.bcond (bcond),
		.moc   (moc),
		.state (state)
	);

	control_encoder control_encoder_inst (
		.state (state),
		.ctl   (ctl)
	);

endmodule

`default_nettype wire

// ==== source/sparc_ctl_macros.svh ====
`ifndef SPARC_CTL_MACROS_SVH
`define SPARC_CTL_MACROS_SVH

// instruction and state widths
`define WORD_W 32
`define STATE_W 7
`define ALU_OP_W 6

// major opcode
`define OP_HI 31
`define OP_LO 30

// format 3 op3 field
`define OP3_HI 24
`define OP3_LO 19

// format 2 op2 field, overlaps op3
`define OP2_HI 24
`define OP2_LO 22

// branch condition and annul
`define COND_HI 28
`define COND_LO 25
`define ANNUL_BIT 29

`define I_BIT 13

`endif

// ==== source/sparc_ctl_pkg.sv ====
`default_nettype none
`include "sparc_ctl_macros.svh"

package sparc_ctl_pkg;

	typedef enum logic [`STATE_W-1:0] {
		S_RESET       = 7'b0000000,
		S_FETCH_ADDR  = 7'b0000001,
		S_FETCH_PC    = 7'b0000010,
		S_FETCH_WAIT  = 7'b0000011,
		S_DECODE      = 7'b0000100,
		S_ALU         = 7'b0001010,
		S_ALU_IMM     = 7'b0001011,
		S_ALU_CC      = 7'b0001100,
		S_ALU_CC_IMM  = 7'b0001101,
		S_SETHI       = 7'b0001110,
		S_LD_ADDR     = 7'b0010100,
		S_LD_REQ      = 7'b0010101,
		S_LD_WAIT     = 7'b0010110,
		S_LD_WB       = 7'b0010111,
		S_ST_ADDR     = 7'b0011001,
		S_ST_DATA     = 7'b0011010,
		S_ST_WAIT     = 7'b0011011,
		S_ST_DONE     = 7'b0011100,
		S_LD_ADDR_IMM = 7'b0011110,
		S_ST_ADDR_IMM = 7'b0100011,
		S_CALL_LINK   = 7'b0101000,
		S_CALL_JUMP   = 7'b0101001,
		S_JMPL_LINK   = 7'b0101010,
		S_JMPL_REG    = 7'b0101011,
		S_JMPL_IMM    = 7'b0101100,
		S_BR_TAKEN    = 7'b0110010,
		S_BR_SKIP     = 7'b0110011,
		S_BR_ANNUL    = 7'b0110100
	} state_t;

	typedef enum logic [1:0] {
		OP_BRANCH = 2'b00,
		OP_CALL   = 2'b01,
		OP_ARITH  = 2'b10,
		OP_MEM    = 2'b11
	} major_op_t;

	typedef enum logic [2:0] {
		OP2_BRANCH = 3'b010,
		OP2_SETHI  = 3'b100
	} op2_t;

	// bit 4 marks the cc variant
	typedef enum logic [5:0] {
		OP3_ADD    = 6'b000000, OP3_ADDCC  = 6'b010000,
		OP3_ADDX   = 6'b001000, OP3_ADDXCC = 6'b011000,
		OP3_SUB    = 6'b000100, OP3_SUBCC  = 6'b010100,
		OP3_SUBX   = 6'b001100, OP3_SUBXCC = 6'b011100,
		OP3_AND    = 6'b000001, OP3_ANDCC  = 6'b010001,
		OP3_ANDN   = 6'b000101, OP3_ANDNCC = 6'b010101,
		OP3_OR     = 6'b000010, OP3_ORCC   = 6'b010010,
		OP3_ORN    = 6'b000110, OP3_ORNCC  = 6'b010110,
		OP3_XOR    = 6'b000011, OP3_XORCC  = 6'b010011,
		OP3_XNOR   = 6'b000111, OP3_XNORCC = 6'b010111,
		OP3_SLL    = 6'b100101,
		OP3_SRL    = 6'b100110,
		OP3_SRA    = 6'b100111,
		OP3_JMPL   = 6'b111000
	} op3_t;

	// only meaningful under OP_MEM
	typedef enum logic [5:0] {
		MEM_LD     = 6'b000000,
		MEM_LDUB   = 6'b000001,
		MEM_LDUH   = 6'b000010,
		MEM_LDD    = 6'b000011,
		MEM_ST     = 6'b000100,
		MEM_STB    = 6'b000101,
		MEM_STH    = 6'b000110,
		MEM_STD    = 6'b000111,
		MEM_LDSB   = 6'b001001,
		MEM_LDSH   = 6'b001010,
		MEM_LDSTUB = 6'b001101
	} mem_op_t;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_SETHI,
		CLS_LOAD,
		CLS_STORE,
		CLS_CALL,
		CLS_JMPL,
		CLS_BRANCH,
		CLS_ILLEGAL
	} instr_class_t;

	typedef struct packed {
		instr_class_t cls;
		logic set_cc;
		logic imm;
		logic annul;
	} decoded_t;

	typedef struct packed {
		logic rf_load_en;
		logic rf_clear_en;
		logic ir_ld;
		logic mar_ld;
		logic mdr_ld;
		logic pc_ld;
		logic npc_ld;
		logic npc_clr;
		logic fr_ld;
		logic r_w;
		logic mov;
		logic [1:0] mem_type;
		logic [1:0] mb;
		logic mm;
		logic [1:0] mnp;
		logic mop;
		logic [1:0] mp;
		logic msa;
		logic link_sel;
		logic [`ALU_OP_W-1:0] alu_op;
	} ctl_word_t;

endpackage

`default_nettype wire

// ==== sparc_ctl.f ====
+incdir+source
source/sparc_ctl_pkg.sv
source/instr_decoder.sv
source/micro_sequencer.sv
source/control_encoder.sv
source/sparc_ctl.sv
bench/sparc_ctl_tb.sv
